//--- source/l2_mem_pkg.sv
/*
 * L2 memory package
 * Geometry of the byte-organized L2, its address and word types
 * and the request word that each engine presents to the memory.
 */
package l2_mem_pkg;

    localparam int unsigned L2_DEPTH   = 4096;  // Bytes
    localparam int unsigned L2_AW      = 12;
    localparam int unsigned WORD_BYTES = 4;

    typedef logic [L2_AW-1:0] l2_addr_t;  // Byte address
    typedef logic [31:0]      l2_word_t;  // Little-endian data word

    // One memory access, held by the requester until granted
    typedef struct packed {
        logic     req;
        logic     we;    // 1 for a word write
        l2_addr_t addr;
        l2_word_t wdata;
    } l2_req_t;

endpackage

//--- source/udma_reg_pkg.sv
/*
 * uDMA channel register package
 * Register map of the configuration port, job description
 * and the layout of the CFG and STATUS registers.
 */
package udma_reg_pkg;

    typedef logic [4:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;
    typedef logic [15:0] xfer_size_t;  // Job size in bytes

    ////////////////////////////////////////////////////////////
    // Register indices
    ////////////////////////////////////////////////////////////
    localparam cfg_addr_t REG_RX_SADDR = 5'd0;
    localparam cfg_addr_t REG_RX_SIZE  = 5'd1;
    localparam cfg_addr_t REG_RX_CFG   = 5'd2;
    localparam cfg_addr_t REG_TX_SADDR = 5'd3;
    localparam cfg_addr_t REG_TX_SIZE  = 5'd4;
    localparam cfg_addr_t REG_TX_CFG   = 5'd5;
    localparam cfg_addr_t REG_STATUS   = 5'd9;

    localparam int unsigned CFG_EN_BIT         = 4;  // Job enable in a CFG register
    localparam int unsigned STATUS_TX_BUSY_BIT = 0;
    localparam int unsigned STATUS_RX_BUSY_BIT = 1;

    typedef struct packed {
        l2_mem_pkg::l2_addr_t saddr;
        xfer_size_t           size;
    } job_cfg_t;

    // Number of 32-bit words that a job touches, partial word rounded up
    function automatic xfer_size_t size_to_words(xfer_size_t size);
        return (size >> 2) + xfer_size_t'(|size[1:0]);
    endfunction

endpackage

//--- source/udma_cfg_regs.sv
/*
 * Configuration register file
 * Holds the RX and TX job registers, issues start pulses to idle
 * engines and builds the combinational readback.
 */
module udma_cfg_regs (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    cfg_valid_i,
    input  logic                    cfg_rwn_i,
    input  udma_reg_pkg::cfg_addr_t cfg_addr_i,
    input  udma_reg_pkg::cfg_data_t cfg_data_i,
    output udma_reg_pkg::cfg_data_t cfg_data_o,
    input  logic                    tx_busy_i,
    input  logic                    rx_busy_i,
    output logic                    tx_start_o,
    output logic                    rx_start_o,
    output udma_reg_pkg::job_cfg_t  tx_job_o,
    output udma_reg_pkg::job_cfg_t  rx_job_o
);
    import udma_reg_pkg::*;
    import l2_mem_pkg::*;

    job_cfg_t tx_job_q;
    job_cfg_t rx_job_q;
    logic     cfg_wr;
    logic     tx_kick;
    logic     rx_kick;

    assign cfg_wr = cfg_valid_i & ~cfg_rwn_i;

    // A start pulse already out counts as busy until the engine answers
    assign tx_kick = cfg_wr & (cfg_addr_i == REG_TX_CFG) & cfg_data_i[CFG_EN_BIT]
                   & (tx_job_q.size != '0) & ~tx_busy_i & ~tx_start_o;
    assign rx_kick = cfg_wr & (cfg_addr_i == REG_RX_CFG) & cfg_data_i[CFG_EN_BIT]
                   & (rx_job_q.size != '0) & ~rx_busy_i & ~rx_start_o;

    assign tx_job_o = tx_job_q;
    assign rx_job_o = rx_job_q;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_job_q   <= '0;
            rx_job_q   <= '0;
            tx_start_o <= 1'b0;
            rx_start_o <= 1'b0;
        end else begin
            tx_start_o <= tx_kick;
            rx_start_o <= rx_kick;
            if (cfg_wr) begin
                case (cfg_addr_i)
                    REG_RX_SADDR: rx_job_q.saddr <= l2_addr_t'(cfg_data_i);  // Truncated
                    REG_RX_SIZE:  rx_job_q.size  <= xfer_size_t'(cfg_data_i);
                    REG_TX_SADDR: tx_job_q.saddr <= l2_addr_t'(cfg_data_i);
                    REG_TX_SIZE:  tx_job_q.size  <= xfer_size_t'(cfg_data_i);
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Readback
    ////////////////////////////////////////////////////////////
    always_comb begin
        cfg_data_o = '0;
        if (cfg_valid_i) begin
            case (cfg_addr_i)
                REG_RX_SADDR: cfg_data_o = cfg_data_t'(rx_job_q.saddr);
                REG_RX_SIZE:  cfg_data_o = cfg_data_t'(rx_job_q.size);
                REG_RX_CFG:   cfg_data_o[CFG_EN_BIT] = rx_busy_i;
                REG_TX_SADDR: cfg_data_o = cfg_data_t'(tx_job_q.saddr);
                REG_TX_SIZE:  cfg_data_o = cfg_data_t'(tx_job_q.size);
                REG_TX_CFG:   cfg_data_o[CFG_EN_BIT] = tx_busy_i;
                REG_STATUS: begin
                    cfg_data_o[STATUS_TX_BUSY_BIT] = tx_busy_i;
                    cfg_data_o[STATUS_RX_BUSY_BIT] = rx_busy_i;
                end
                default: cfg_data_o = '0;
            endcase
        end
    end

endmodule

//--- source/udma_tx_streamer.sv
/*
 * TX streamer
 * Reads a job's words from L2 in ascending order and presents them
 * on the outgoing stream, with one prefetched word behind the output.
 */
module udma_tx_streamer (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  udma_reg_pkg::job_cfg_t job_i,
    output logic                   busy_o,
    output l2_mem_pkg::l2_req_t    mem_req_o,
    input  logic                   mem_gnt_i,
    input  l2_mem_pkg::l2_word_t   mem_rdata_i,
    output l2_mem_pkg::l2_word_t   tx_data_o,
    output logic                   tx_valid_o,
    input  logic                   tx_ready_i,
    output logic                   eot_o
);
    import udma_reg_pkg::*;
    import l2_mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WAIT_DATA,
        ST_SEND
    } tx_state_e;

    tx_state_e  state_q;
    l2_addr_t   addr_q;
    xfer_size_t fetch_left_q;  // Words not yet requested
    xfer_size_t send_left_q;   // Words not yet taken
    l2_word_t   pf_data_q;
    logic       pf_valid_q;
    logic       take;
    logic       rd_valid;
    logic       slot_free;

    assign take     = tx_valid_o & tx_ready_i;
    assign rd_valid = (state_q == ST_WAIT_DATA);  // Read data arrives this cycle

    // Prefetch slot is empty after this edge, so a new read has a place to land
    assign slot_free = rd_valid ? ~(tx_valid_o & ~take) : (~pf_valid_q | take);

    assign mem_req_o = '{req: (state_q == ST_FETCH), we: 1'b0, addr: addr_q, wdata: '0};

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= ST_IDLE;
            busy_o       <= 1'b0;
            eot_o        <= 1'b0;
            fetch_left_q <= '0;
            send_left_q  <= '0;
        end else begin
            eot_o <= 1'b0;
            if (take) send_left_q <= send_left_q - 1'b1;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        busy_o       <= 1'b1;
                        fetch_left_q <= size_to_words(job_i.size);
                        send_left_q  <= size_to_words(job_i.size);
                        state_q      <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (mem_gnt_i) begin
                        fetch_left_q <= fetch_left_q - 1'b1;
                        state_q      <= ST_WAIT_DATA;
                    end
                end
                ST_WAIT_DATA: begin
                    state_q <= (fetch_left_q != '0 && slot_free) ? ST_FETCH : ST_SEND;
                end
                ST_SEND: begin
                    if (take && send_left_q == xfer_size_t'(1)) begin  // Last word leaves
                        busy_o  <= 1'b0;
                        eot_o   <= 1'b1;
                        state_q <= ST_IDLE;
                    end else if (fetch_left_q != '0 && slot_free) begin
                        state_q <= ST_FETCH;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Output and prefetch occupancy
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid_o <= 1'b0;
            pf_valid_q <= 1'b0;
        end else if (rd_valid) begin
            if (tx_valid_o && !take) pf_valid_q <= 1'b1;  // Output still stalled
            else                     tx_valid_o <= 1'b1;
        end else if (take) begin
            if (pf_valid_q) pf_valid_q <= 1'b0;
            else            tx_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state_q == ST_IDLE && start_i) begin
            addr_q <= job_i.saddr;
        end else if (state_q == ST_FETCH && mem_gnt_i) begin
            addr_q <= addr_q + l2_addr_t'(WORD_BYTES);
        end
        if (rd_valid) begin
            if (!tx_valid_o || take) tx_data_o <= mem_rdata_i;
            else                     pf_data_q <= mem_rdata_i;
        end else if (take && pf_valid_q) begin
            tx_data_o <= pf_data_q;  // Prefetched word moves up
        end
    end

endmodule

//--- source/udma_rx_writer.sv
/*
 * RX writer
 * Takes words from the incoming stream and writes each one
 * into L2 at the next word address of the running job.
 */
module udma_rx_writer (
    input  logic                   sys_clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  udma_reg_pkg::job_cfg_t job_i,
    output logic                   busy_o,
    input  l2_mem_pkg::l2_word_t   rx_data_i,
    input  logic                   rx_valid_i,
    output logic                   rx_ready_o,
    output l2_mem_pkg::l2_req_t    mem_req_o,
    input  logic                   mem_gnt_i,
    output logic                   eot_o
);
    import udma_reg_pkg::*;
    import l2_mem_pkg::*;

    l2_addr_t   addr_q;
    l2_word_t   wdata_q;
    xfer_size_t words_left_q;
    logic       pend_q;  // Word waiting for its write grant
    logic       accept;

    assign rx_ready_o = busy_o & ~pend_q;
    assign accept     = rx_valid_i & rx_ready_o;
    assign mem_req_o  = '{req: pend_q, we: 1'b1, addr: addr_q, wdata: wdata_q};

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o       <= 1'b0;
            eot_o        <= 1'b0;
            pend_q       <= 1'b0;
            words_left_q <= '0;
        end else begin
            eot_o <= 1'b0;
            if (start_i && !busy_o) begin
                busy_o       <= 1'b1;
                words_left_q <= size_to_words(job_i.size);
            end
            if (accept) begin
                pend_q <= 1'b1;
            end else if (mem_gnt_i) begin
                pend_q       <= 1'b0;
                words_left_q <= words_left_q - 1'b1;
                if (words_left_q == xfer_size_t'(1)) begin  // Last word written
                    busy_o <= 1'b0;
                    eot_o  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (start_i && !busy_o) addr_q <= job_i.saddr;
        else if (mem_gnt_i)     addr_q <= addr_q + l2_addr_t'(WORD_BYTES);
        if (accept) wdata_q <= rx_data_i;
    end

endmodule

//--- source/l2_shared_mem.sv
/*
 * Shared L2 memory
 * Round-robin arbiter for the TX and RX ports in front of a
 * byte array with word writes and registered word reads.
 */
module l2_shared_mem (
    input  logic                 sys_clk,
    input  logic                 rst_n,
    input  l2_mem_pkg::l2_req_t  tx_req_i,
    input  l2_mem_pkg::l2_req_t  rx_req_i,
    output logic                 tx_gnt_o,
    output logic                 rx_gnt_o,
    output l2_mem_pkg::l2_word_t rdata_o
);
    import l2_mem_pkg::*;

    logic [7:0] mem_q [L2_DEPTH];
    logic       last_rx_q;  // RX won the previous grant
    l2_req_t    sel_req;
    logic       gnt;

    ////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////
    assign tx_gnt_o = tx_req_i.req & (~rx_req_i.req | last_rx_q);
    assign rx_gnt_o = rx_req_i.req & (~tx_req_i.req | ~last_rx_q);
    assign gnt      = tx_gnt_o | rx_gnt_o;
    assign sel_req  = rx_gnt_o ? rx_req_i : tx_req_i;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            last_rx_q <= 1'b0;
        end else if (gnt) begin
            last_rx_q <= rx_gnt_o;
        end
    end

    ////////////////////////////////////////////////////////////
    // Byte array, little-endian
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sys_clk) begin
        if (gnt) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                if (sel_req.we) begin
                    mem_q[sel_req.addr + l2_addr_t'(i)] <= sel_req.wdata[8*i +: 8];
                end else begin
                    rdata_o[8*i +: 8] <= mem_q[sel_req.addr + l2_addr_t'(i)];  // Wraps at 4 KB
                end
            end
        end
    end

endmodule

//--- source/udma_channel.sv
/*
 * uDMA peripheral channel
 * Configuration registers, TX streamer and RX writer sharing one L2.
 */
module udma_channel (
    input  logic                    sys_clk,
    input  logic                    rst_n,
    input  logic                    cfg_valid_i,
    input  logic                    cfg_rwn_i,
    input  udma_reg_pkg::cfg_addr_t cfg_addr_i,
    input  udma_reg_pkg::cfg_data_t cfg_data_i,
    output udma_reg_pkg::cfg_data_t cfg_data_o,
    output l2_mem_pkg::l2_word_t    tx_data_o,
    output logic                    tx_valid_o,
    input  logic                    tx_ready_i,
    input  l2_mem_pkg::l2_word_t    rx_data_i,
    input  logic                    rx_valid_i,
    output logic                    rx_ready_o,
    output logic                    evt_tx_eot_o,
    output logic                    evt_rx_eot_o
);
    import udma_reg_pkg::*;
    import l2_mem_pkg::*;

    job_cfg_t tx_job;
    job_cfg_t rx_job;
    logic     tx_start;
    logic     rx_start;
    logic     tx_busy;
    logic     rx_busy;
    l2_req_t  tx_req;
    l2_req_t  rx_req;
    logic     tx_gnt;
    logic     rx_gnt;
    l2_word_t mem_rdata;  // Seen by both engines

    udma_cfg_regs i_cfg_regs (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .cfg_valid_i (cfg_valid_i),
        .cfg_rwn_i   (cfg_rwn_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_data_i  (cfg_data_i),
        .cfg_data_o  (cfg_data_o),
        .tx_busy_i   (tx_busy),
        .rx_busy_i   (rx_busy),
        .tx_start_o  (tx_start),
        .rx_start_o  (rx_start),
        .tx_job_o    (tx_job),
        .rx_job_o    (rx_job)
    );

    udma_tx_streamer i_tx_streamer (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .start_i     (tx_start),
        .job_i       (tx_job),
        .busy_o      (tx_busy),
        .mem_req_o   (tx_req),
        .mem_gnt_i   (tx_gnt),
        .mem_rdata_i (mem_rdata),
        .tx_data_o   (tx_data_o),
        .tx_valid_o  (tx_valid_o),
        .tx_ready_i  (tx_ready_i),
        .eot_o       (evt_tx_eot_o)
    );

    udma_rx_writer i_rx_writer (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .start_i    (rx_start),
        .job_i      (rx_job),
        .busy_o     (rx_busy),
        .rx_data_i  (rx_data_i),
        .rx_valid_i (rx_valid_i),
        .rx_ready_o (rx_ready_o),
        .mem_req_o  (rx_req),
        .mem_gnt_i  (rx_gnt),
        .eot_o      (evt_rx_eot_o)
    );

    l2_shared_mem i_l2_mem (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .tx_req_i (tx_req),
        .rx_req_i (rx_req),
        .tx_gnt_o (tx_gnt),
        .rx_gnt_o (rx_gnt),
        .rdata_o  (mem_rdata)
    );

endmodule

//--- test/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 10 ns clock, reset held low for the first 5 cycles.
 */
module tb_clock_gen (
    output logic sys_clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 5;

    initial begin
        sys_clk_o = 1'b0;
        forever #5 sys_clk_o = ~sys_clk_o;  // 10 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- test/udma_channel_properties.sv
/*
 * Interface rules of the uDMA channel
 * Stream hold under back-pressure, single-cycle EOT pulses, RX ready gating.
 */
module udma_channel_properties (
    input logic                 sys_clk,
    input logic                 rst_n,
    input l2_mem_pkg::l2_word_t tx_data_i,
    input logic                 tx_valid_i,
    input logic                 tx_ready_i,
    input logic                 rx_ready_i,
    input logic                 rx_start_i,
    input logic                 evt_tx_eot_i,
    input logic                 evt_rx_eot_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic rx_job_q;  // RX job from its start pulse through its EOT pulse

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_job_q <= 1'b0;
        end else if (rx_start_i) begin
            rx_job_q <= 1'b1;
        end else if (evt_rx_eot_i) begin
            rx_job_q <= 1'b0;
        end
    end

    // Stalled word stays on the bus
    a_tx_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (tx_valid_i && !tx_ready_i) |=> (tx_valid_i && $stable(tx_data_i)))
        else $error("TX word changed or dropped under back-pressure");

    a_tx_eot_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
        evt_tx_eot_i |=> !evt_tx_eot_i)
        else $error("TX end-of-transfer held for more than one cycle");

    a_rx_eot_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
        evt_rx_eot_i |=> !evt_rx_eot_i)
        else $error("RX end-of-transfer held for more than one cycle");

    a_rx_ready_busy: assert property (@(posedge sys_clk) disable iff (!rst_n)
        rx_ready_i |-> (rx_job_q && !evt_rx_eot_i))
        else $error("RX ready raised with no RX job running");

endmodule

bind udma_channel udma_channel_properties u_properties (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .tx_data_i    (tx_data_o),
    .tx_valid_i   (tx_valid_o),
    .tx_ready_i   (tx_ready_i),
    .rx_ready_i   (rx_ready_o),
    .rx_start_i   (rx_start),
    .evt_tx_eot_i (evt_tx_eot_o),
    .evt_rx_eot_i (evt_rx_eot_o)
);

//--- test/tb_udma_channel.sv
/*
 * Testbench for the uDMA channel
 * Directed tests of register readback, RX and TX jobs, back-pressure,
 * concurrent jobs and ignored starts, checked against a word model of L2.
 */
module tb_udma_channel;
    timeunit 1ns;
    timeprecision 1ps;

    import udma_reg_pkg::*;
    import l2_mem_pkg::*;

    localparam int RAND_SEED       = 22284;
    localparam int REGION_A        = 'h100;
    localparam int REGION_B        = 'h400;
    localparam int REGION_C        = 'h800;
    localparam int WORDS_A         = 16;
    localparam int WORDS_B         = 8;
    localparam int WORDS_C         = 4;
    localparam int SIZE_LONG       = 40;  // Bytes
    localparam int SIZE_ODD        = 10;  // Ends in a partial word
    localparam int TOTAL_WORDS     = 3 * WORDS_A + (SIZE_LONG + 3) / 4 + (SIZE_ODD + 3) / 4
                                   + 2 * WORDS_B + 2 * WORDS_C;
    localparam int CYCLES_PER_WORD = 40;
    localparam int TIMEOUT_MARGIN  = 1000;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * CYCLES_PER_WORD + TIMEOUT_MARGIN;

    localparam cfg_data_t JOB_EN  = cfg_data_t'(1) << CFG_EN_BIT;
    localparam cfg_data_t TX_BUSY = cfg_data_t'(1) << STATUS_TX_BUSY_BIT;
    localparam cfg_data_t RX_BUSY = cfg_data_t'(1) << STATUS_RX_BUSY_BIT;

    logic      sys_clk;
    logic      rst_n;
    logic      cfg_valid_i;
    logic      cfg_rwn_i;
    cfg_addr_t cfg_addr_i;
    cfg_data_t cfg_data_i;
    cfg_data_t cfg_data_o;
    l2_word_t  tx_data_o;
    logic      tx_valid_o;
    logic      tx_ready_i;
    l2_word_t  rx_data_i;
    logic      rx_valid_i;
    logic      rx_ready_o;
    logic      evt_tx_eot_o;
    logic      evt_rx_eot_o;

    l2_word_t  ref_mem [int];  // Expected L2 contents, by word address
    int        tx_eot_count = 0;
    int        rx_eot_count = 0;
    int        tx_eot_exp   = 0;
    int        rx_eot_exp   = 0;

    tb_clock_gen u_clock_gen (
        .sys_clk_o (sys_clk),
        .rst_n_o   (rst_n)
    );

    udma_channel UUT (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .cfg_valid_i  (cfg_valid_i),
        .cfg_rwn_i    (cfg_rwn_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_data_i   (cfg_data_i),
        .cfg_data_o   (cfg_data_o),
        .tx_data_o    (tx_data_o),
        .tx_valid_o   (tx_valid_o),
        .tx_ready_i   (tx_ready_i),
        .rx_data_i    (rx_data_i),
        .rx_valid_i   (rx_valid_i),
        .rx_ready_o   (rx_ready_o),
        .evt_tx_eot_o (evt_tx_eot_o),
        .evt_rx_eot_o (evt_rx_eot_o)
    );

    always @(negedge sys_clk) begin
        if (evt_tx_eot_o) tx_eot_count++;
        if (evt_rx_eot_o) rx_eot_count++;
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////
    task automatic halt_run();
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input string name, input l2_word_t got, input l2_word_t want);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
            halt_run();
        end
    endtask

    task automatic check_cfg(input string name, input cfg_data_t got, input cfg_data_t want);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
            halt_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, want);
            halt_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus and stream helpers
    ////////////////////////////////////////////////////////////
    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        @(posedge sys_clk);
        cfg_valid_i <= 1'b1;
        cfg_rwn_i   <= 1'b0;
        cfg_addr_i  <= addr;
        cfg_data_i  <= data;
        @(posedge sys_clk);
        cfg_valid_i <= 1'b0;
    endtask

    task automatic expect_reg(input cfg_addr_t addr, input cfg_data_t want, input string name);
        @(posedge sys_clk);
        cfg_valid_i <= 1'b1;
        cfg_rwn_i   <= 1'b1;
        cfg_addr_i  <= addr;
        @(negedge sys_clk);  // Readback is combinational
        check_cfg(name, cfg_data_o, want);
        @(posedge sys_clk);
        cfg_valid_i <= 1'b0;
    endtask

    task automatic start_job(input bit tx, input int saddr, input int size);
        write_reg(tx ? REG_TX_SADDR : REG_RX_SADDR, cfg_data_t'(saddr));
        write_reg(tx ? REG_TX_SIZE : REG_RX_SIZE, cfg_data_t'(size));
        write_reg(tx ? REG_TX_CFG : REG_RX_CFG, JOB_EN);
    endtask

    task automatic fill_region(input int saddr, input int n, output l2_word_t words[$]);
        l2_word_t w;
        for (int i = 0; i < n; i++) begin
            w = l2_word_t'($urandom);
            ref_mem[saddr + 4 * i] = w;
            words.push_back(w);
        end
    endtask

    task automatic expected_words(input int saddr, input int size, output l2_word_t words[$]);
        for (int i = 0; i < (size + 3) / 4; i++) begin  // Partial last word still goes out
            words.push_back(ref_mem[saddr + 4 * i]);
        end
    endtask

    task automatic send_rx(input l2_word_t words[$]);
        int idx = 0;
        while (idx < words.size()) begin
            @(posedge sys_clk);
            rx_valid_i <= 1'b1;
            rx_data_i  <= words[idx];
            @(negedge sys_clk);
            if (rx_ready_o) idx++;  // Taken at the coming edge
        end
        @(posedge sys_clk);
        rx_valid_i <= 1'b0;
        rx_eot_exp++;
        while (rx_eot_count < rx_eot_exp) @(negedge sys_clk);
    endtask

    task automatic collect_tx(input l2_word_t want[$], input bit stall);
        int n_got = 0;
        while (n_got < want.size()) begin
            @(posedge sys_clk);
            tx_ready_i <= stall ? ($urandom_range(1, 0) != 0) : 1'b1;
            @(negedge sys_clk);
            if (tx_valid_o && tx_ready_i) begin
                check_word($sformatf("tx_data_o word %0d", n_got), tx_data_o, want[n_got]);
                n_got++;
            end
        end
        @(posedge sys_clk);
        tx_ready_i <= 1'b0;
        @(negedge sys_clk);  // One cycle after the last word
        check_bit("evt_tx_eot_o", evt_tx_eot_o, 1'b1);
        tx_eot_exp++;
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(negedge sys_clk);
            check_bit("tx_valid_o", tx_valid_o, 1'b0);
            check_bit("rx_ready_o", rx_ready_o, 1'b0);
        end
        if (tx_eot_count != tx_eot_exp || rx_eot_count != rx_eot_exp) begin
            $display("Wrong end-of-transfer count: TX %0d of %0d, RX %0d of %0d",
                     tx_eot_count, tx_eot_exp, rx_eot_count, rx_eot_exp);
            halt_run();
        end
    endtask

    task automatic check_truncation(input cfg_addr_t addr, input cfg_data_t keep,
                                    input string name);
        cfg_data_t value;
        value = cfg_data_t'($urandom) | ~keep;  // Upper bits set so the cut shows
        write_reg(addr, value);
        expect_reg(addr, value & keep, name);
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        cfg_addr_t regs [7] = '{REG_RX_SADDR, REG_RX_SIZE, REG_RX_CFG, REG_TX_SADDR,
                                REG_TX_SIZE, REG_TX_CFG, REG_STATUS};
        @(negedge sys_clk);
        check_bit("tx_valid_o", tx_valid_o, 1'b0);
        check_bit("rx_ready_o", rx_ready_o, 1'b0);
        check_bit("evt_tx_eot_o", evt_tx_eot_o, 1'b0);
        check_bit("evt_rx_eot_o", evt_rx_eot_o, 1'b0);
        foreach (regs[i]) begin
            expect_reg(regs[i], '0, $sformatf("register %0d", regs[i]));
        end
    endtask

    task automatic test_reg_readback();
        check_truncation(REG_RX_SADDR, 32'h0000_0FFF, "RX_SADDR");
        check_truncation(REG_RX_SIZE, 32'h0000_FFFF, "RX_SIZE");
        check_truncation(REG_TX_SADDR, 32'h0000_0FFF, "TX_SADDR");
        check_truncation(REG_TX_SIZE, 32'h0000_FFFF, "TX_SIZE");
    endtask

    task automatic test_rx_then_tx();
        l2_word_t words[$];
        l2_word_t want[$];
        fill_region(REGION_A, WORDS_A, words);
        start_job(1'b0, REGION_A, WORDS_A * 4);
        expect_reg(REG_STATUS, RX_BUSY, "STATUS");
        expect_reg(REG_RX_CFG, JOB_EN, "RX_CFG");
        send_rx(words);
        watch_idle(8);
        expect_reg(REG_STATUS, '0, "STATUS");
        expected_words(REGION_A, WORDS_A * 4, want);
        start_job(1'b1, REGION_A, WORDS_A * 4);
        expect_reg(REG_STATUS, TX_BUSY, "STATUS");  // Held busy, ready still low
        expect_reg(REG_TX_CFG, JOB_EN, "TX_CFG");
        collect_tx(want, 1'b0);
        watch_idle(8);
        expect_reg(REG_STATUS, '0, "STATUS");
    endtask

    task automatic test_tx_backpressure();
        l2_word_t want[$];
        expected_words(REGION_A, SIZE_LONG, want);
        start_job(1'b1, REGION_A, SIZE_LONG);
        collect_tx(want, 1'b1);
        watch_idle(8);
        expected_words(REGION_A, SIZE_ODD, want);
        start_job(1'b1, REGION_A, SIZE_ODD);
        collect_tx(want, 1'b1);
        watch_idle(8);
    endtask

    task automatic test_concurrent();
        l2_word_t want_a[$];
        l2_word_t words_b[$];
        l2_word_t want_b[$];
        expected_words(REGION_A, WORDS_A * 4, want_a);
        fill_region(REGION_B, WORDS_B, words_b);
        start_job(1'b1, REGION_A, WORDS_A * 4);
        start_job(1'b0, REGION_B, WORDS_B * 4);
        fork
            collect_tx(want_a, 1'b1);
            send_rx(words_b);
        join
        watch_idle(8);
        expected_words(REGION_B, WORDS_B * 4, want_b);  // Confirms what RX stored
        start_job(1'b1, REGION_B, WORDS_B * 4);
        collect_tx(want_b, 1'b0);
        watch_idle(8);
    endtask

    task automatic test_ignored_starts();
        l2_word_t want[$];
        l2_word_t words[$];
        expected_words(REGION_A, WORDS_C * 4, want);
        start_job(1'b1, REGION_A, WORDS_C * 4);
        write_reg(REG_TX_CFG, JOB_EN);  // TX busy, no restart
        collect_tx(want, 1'b0);
        fill_region(REGION_C, WORDS_C, words);
        start_job(1'b0, REGION_C, WORDS_C * 4);
        write_reg(REG_RX_CFG, JOB_EN);
        send_rx(words);
        watch_idle(20);
        start_job(1'b1, REGION_A, 0);  // Zero size never starts
        start_job(1'b0, REGION_C, 0);
        watch_idle(20);
        expect_reg(REG_STATUS, '0, "STATUS");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        cfg_valid_i = 1'b0;
        cfg_rwn_i   = 1'b1;
        cfg_addr_i  = '0;
        cfg_data_i  = '0;
        tx_ready_i  = 1'b0;
        rx_data_i   = '0;
        rx_valid_i  = 1'b0;
        void'($urandom(RAND_SEED));
        @(posedge rst_n);
        test_reset_state();
        test_reg_readback();
        test_rx_then_tx();
        test_tx_backpressure();
        test_concurrent();
        test_ignored_starts();
        $display("Testbench passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        halt_run();
    end

endmodule

//--- udma_channel.f
source/l2_mem_pkg.sv
source/udma_reg_pkg.sv
source/udma_cfg_regs.sv
source/udma_tx_streamer.sv
source/udma_rx_writer.sv
source/l2_shared_mem.sv
source/udma_channel.sv
test/tb_clock_gen.sv
test/udma_channel_properties.sv
test/tb_udma_channel.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_udma_channel
FILELIST  := udma_channel.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0 \
             --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
